//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbRiscvCore
FILELIST = list.f
BUILD    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# pass only if the run prints the pass line
run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD)

//--- list.f
+incdir+include
source/rvPkg.sv
source/hazardUnit.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/riscvCore.sv
testbench/tbRiscvCore.sv

//--- source/decodeStage.sv
/* decode stage
   control, immediates, register file, branch resolve and decode/execute register */
`timescale 1ns/1ps
`default_nettype none

module decodeStage
	import rvPkg::*;
(
	input  logic    clk,
	input  logic    arstN,
	input  logic    freeze,
	input  logic    stallD,
	input  logic    fwdAD,
	input  logic    fwdBD,
	input  wordT    instD,
	input  wordT    pcD,
	input  wordT    pcPlus4D,
	input  wordT    aluM,
	input  logic    regWriteW,
	input  regAddrT rdW,
	input  wordT    resultW,
	output logic    redirect,
	output wordT    target,
	output regAddrT rsD,
	output regAddrT rtD,
	output wordT    aE,
	output wordT    bE,
	output wordT    immE,
	output aluOpT   aluOpE,
	output logic    aluSrcE,
	output logic    regWriteE,
	output logic    memReadE,
	output logic    memWriteE,
	output regAddrT rsE,
	output regAddrT rtE,
	output regAddrT rdE
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	regAddrT rdD;
	wordT immI, immS, immB, immU, immJ, immD;
	aluOpT aluOpD;
	logic aluSrcD, regWriteD, memReadD, memWriteD, branchD, jalD;
	logic useRs, useRt;
	wordT regs [32];
	wordT rfA, rfB, cmpA, cmpB;
	logic equalD;

	assign opcode = instD[6:0];
	assign funct3 = instD[14:12];
	assign rdD = instD[11:7];

	// sign-extended immediates per format
	assign immI = {{20{instD[31]}}, instD[31:20]};
	assign immS = {{20{instD[31]}}, instD[31:25], instD[11:7]};
	assign immB = {{20{instD[31]}}, instD[7], instD[30:25], instD[11:8], 1'b0};
	assign immU = {instD[31:12], 12'b0};
	assign immJ = {{12{instD[31]}}, instD[19:12], instD[20], instD[30:21], 1'b0};

	always_comb begin
		aluOpD = aluAdd;
		aluSrcD = 1'b0;
		regWriteD = 1'b0;
		memReadD = 1'b0;
		memWriteD = 1'b0;
		branchD = 1'b0;
		jalD = 1'b0;
		useRs = 1'b0;
		useRt = 1'b0;
		immD = immI;
		case (opcode)
			opR: begin
				regWriteD = 1'b1;
				useRs = 1'b1;
				useRt = 1'b1;
				case (funct3)
					f3Add: aluOpD = instD[30] ? aluSub : aluAdd;
					f3Slt: aluOpD = aluSlt;
					f3Xor: aluOpD = aluXor;
					f3Or: aluOpD = aluOr;
					f3And: aluOpD = aluAnd;
					// unsupported funct3 retires with no effect
					default: regWriteD = 1'b0;
				endcase
			end
			// addi only
			opI: begin
				regWriteD = 1'b1;
				aluSrcD = 1'b1;
				useRs = 1'b1;
			end
			opLui: begin
				regWriteD = 1'b1;
				aluSrcD = 1'b1;
				aluOpD = aluPassB;
				immD = immU;
			end
			opLoad: begin
				regWriteD = 1'b1;
				memReadD = 1'b1;
				aluSrcD = 1'b1;
				useRs = 1'b1;
			end
			opStore: begin
				memWriteD = 1'b1;
				aluSrcD = 1'b1;
				useRs = 1'b1;
				useRt = 1'b1;
				immD = immS;
			end
			opBranch: begin
				branchD = 1'b1;
				useRs = 1'b1;
				useRt = 1'b1;
			end
			// link value rides the pass-b path as the immediate
			opJal: begin
				jalD = 1'b1;
				regWriteD = 1'b1;
				aluSrcD = 1'b1;
				aluOpD = aluPassB;
				immD = pcPlus4D;
			end
			default: ;
		endcase
	end

	// unused source fields read as x0 so they never raise a hazard
	assign rsD = useRs ? instD[19:15] : '0;
	assign rtD = useRt ? instD[24:20] : '0;

	// write-through from writeback
	assign rfA = (regWriteW && rdW != '0 && rdW == rsD) ? resultW : regs[rsD];
	assign rfB = (regWriteW && rdW != '0 && rdW == rtD) ? resultW : regs[rtD];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (regWriteW && rdW != '0) begin
			regs[rdW] <= resultW;
		end
	end

	// branch compare, memory-stage result forwarded in
	assign cmpA = fwdAD ? aluM : rfA;
	assign cmpB = fwdBD ? aluM : rfB;
	assign equalD = (cmpA == cmpB);
	assign redirect = jalD | (branchD & (((funct3 == f3Beq) & equalD) |
		((funct3 == f3Bne) & ~equalD)));
	assign target = pcD + (jalD ? immJ : immB);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			aE <= '0;
			bE <= '0;
			immE <= '0;
			aluOpE <= aluAdd;
			aluSrcE <= 1'b0;
			regWriteE <= 1'b0;
			memReadE <= 1'b0;
			memWriteE <= 1'b0;
			rsE <= '0;
			rtE <= '0;
			rdE <= '0;
		end else if (!freeze) begin
			aE <= rfA;
			bE <= rfB;
			immE <= immD;
			aluOpE <= aluOpD;
			aluSrcE <= aluSrcD;
			rsE <= rsD;
			rtE <= rtD;
			// held instruction leaves a bubble behind
			regWriteE <= regWriteD & ~stallD;
			memReadE <= memReadD & ~stallD;
			memWriteE <= memWriteD & ~stallD;
			rdE <= stallD ? '0 : rdD;
		end
	end
endmodule

`default_nettype wire

//--- source/executeStage.sv
/* execute, memory and writeback stages
   forwarding, alu, data port drive and result select */
`timescale 1ns/1ps
`default_nettype none

module executeStage
	import rvPkg::*;
(
	input  logic    clk,
	input  logic    arstN,
	input  logic    freeze,
	input  logic    dataWait,
	input  wordT    aE,
	input  wordT    bE,
	input  wordT    immE,
	input  aluOpT   aluOpE,
	input  logic    aluSrcE,
	input  logic    regWriteE,
	input  logic    memReadE,
	input  logic    memWriteE,
	input  regAddrT rdE,
	input  fwdSelT  fwdAE,
	input  fwdSelT  fwdBE,
	input  wordT    dataRdata,
	output wordT    aluM,
	output logic    regWriteM,
	output logic    memReadM,
	output regAddrT rdM,
	output wordT    dataAddr,
	output wordT    dataWdata,
	output logic    dataWe,
	output logic    dataReq,
	output logic    regWriteW,
	output regAddrT rdW,
	output wordT    resultW
);
	wordT srcA, srcB, aluB, aluE;
	wordT writeDataM;
	logic memWriteM;
	// set once the access has finished while fetch still holds the pipe
	logic memDone;
	wordT loadHold;
	wordT aluW, readDataW;
	logic memToRegW;

	function automatic wordT pickOperand(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
		case (sel)
			fwdMem: pickOperand = memVal;
			fwdWb: pickOperand = wbVal;
			default: pickOperand = regVal;
		endcase
	endfunction

	assign srcA = pickOperand(fwdAE, aE, aluM, resultW);
	// forwarded b is also the store data
	assign srcB = pickOperand(fwdBE, bE, aluM, resultW);
	assign aluB = aluSrcE ? immE : srcB;

	always_comb begin
		case (aluOpE)
			aluAdd: aluE = srcA + aluB;
			aluSub: aluE = srcA - aluB;
			aluAnd: aluE = srcA & aluB;
			aluOr: aluE = srcA | aluB;
			aluXor: aluE = srcA ^ aluB;
			aluSlt: aluE = {{(xlen-1){1'b0}}, $signed(srcA) < $signed(aluB)};
			aluPassB: aluE = aluB;
			default: aluE = srcA + aluB;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			aluM <= '0;
			writeDataM <= '0;
			regWriteM <= 1'b0;
			memReadM <= 1'b0;
			memWriteM <= 1'b0;
			rdM <= '0;
		end else if (!freeze) begin
			aluM <= aluE;
			writeDataM <= srcB;
			regWriteM <= regWriteE;
			memReadM <= memReadE;
			memWriteM <= memWriteE;
			rdM <= rdE;
		end
	end

	// word access only
	assign dataAddr = aluM;
	assign dataWdata = writeDataM;
	assign dataWe = memWriteM;
	assign dataReq = (memReadM | memWriteM) & ~memDone;

	// keeps a store from landing twice during an instruction wait
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			memDone <= 1'b0;
		end else if (!freeze) begin
			memDone <= 1'b0;
		end else if (dataReq && !dataWait) begin
			memDone <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (dataReq && !dataWait) begin
			loadHold <= dataRdata;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			aluW <= '0;
			readDataW <= '0;
			memToRegW <= 1'b0;
			regWriteW <= 1'b0;
			rdW <= '0;
		end else if (!freeze) begin
			aluW <= aluM;
			readDataW <= memDone ? loadHold : dataRdata;
			memToRegW <= memReadM;
			regWriteW <= regWriteM;
			rdW <= rdM;
		end
	end

	assign resultW = memToRegW ? readDataW : aluW;
endmodule

`default_nettype wire

//--- source/fetchStage.sv
/* fetch stage
   program counter, next pc choice and the fetch/decode register */
`timescale 1ns/1ps
`default_nettype none

module fetchStage
	import rvPkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  logic freeze,
	input  logic stallD,
	input  logic flushD,
	input  logic redirect,
	input  wordT target,
	input  wordT instData,
	output wordT instAddr,
	output wordT instD,
	output wordT pcD,
	output wordT pcPlus4D
);
	wordT pcF;
	wordT pcPlus4F;
	wordT pcNext;
	logic hold;

	assign pcPlus4F = pcF + 32'd4;
	// static not-taken, decode overrides on a taken branch or jal
	assign pcNext = redirect ? target : pcPlus4F;
	assign hold = freeze | stallD;
	assign instAddr = pcF;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcF <= resetPc;
		end else if (!hold) begin
			pcF <= pcNext;
		end
	end

	// wrong-path word is swapped for a bubble
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			instD <= nopInst;
			pcD <= resetPc;
			pcPlus4D <= resetPc;
		end else if (!hold) begin
			instD <= flushD ? nopInst : instData;
			pcD <= pcF;
			pcPlus4D <= pcPlus4F;
		end
	end
endmodule

`default_nettype wire

//--- source/hazardUnit.sv
/* hazard unit
   operand forwarding, load-use and branch stalls, wrong-path flush */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
	import rvPkg::*;
(
	input  regAddrT rsD,
	input  regAddrT rtD,
	input  regAddrT rsE,
	input  regAddrT rtE,
	input  regAddrT rdE,
	input  regAddrT rdM,
	input  regAddrT rdW,
	input  logic    regWriteE,
	input  logic    memReadE,
	input  logic    regWriteM,
	input  logic    memReadM,
	input  logic    regWriteW,
	input  logic    branchD,
	input  logic    redirect,
	output fwdSelT  fwdAE,
	output fwdSelT  fwdBE,
	output logic    fwdAD,
	output logic    fwdBD,
	output logic    stallD,
	output logic    flushD
);
	logic lwStall;
	logic brStall;

	// newest producer wins, x0 never forwarded
	assign fwdAE = (rsE != '0 && regWriteM && rsE == rdM) ? fwdMem :
		(rsE != '0 && regWriteW && rsE == rdW) ? fwdWb : fwdReg;
	assign fwdBE = (rtE != '0 && regWriteM && rtE == rdM) ? fwdMem :
		(rtE != '0 && regWriteW && rtE == rdW) ? fwdWb : fwdReg;

	// alu result only, load data is not there yet
	assign fwdAD = rsD != '0 && regWriteM && !memReadM && rsD == rdM;
	assign fwdBD = rtD != '0 && regWriteM && !memReadM && rtD == rdM;

	// load in execute feeding decode
	assign lwStall = memReadE && rdE != '0 && (rdE == rsD || rdE == rtD);
	// branch operand still in execute, or a load in memory
	assign brStall = branchD && (
		(regWriteE && rdE != '0 && (rdE == rsD || rdE == rtD)) ||
		(memReadM && rdM != '0 && (rdM == rsD || rdM == rtD)));

	assign stallD = lwStall | brStall;
	// redirect from stale operands is ignored while held
	assign flushD = redirect & ~stallD;
endmodule

`default_nettype wire

//--- source/riscvCore.sv
/* five-stage rv32i subset core
   joins the stages, the hazard unit and both memory ports */
`timescale 1ns/1ps
`default_nettype none

module riscvCore
	import rvPkg::*;
(
	input  logic clk,
	input  logic arstN,
	output wordT instAddr,
	input  wordT instData,
	input  logic instWait,
	output wordT dataAddr,
	output wordT dataWdata,
	output logic dataWe,
	output logic dataReq,
	input  wordT dataRdata,
	input  logic dataWait
);
	logic freeze;
	logic stallD, flushD, redirect, branchD;
	logic fwdAD, fwdBD;
	wordT target, instD, pcD, pcPlus4D;
	regAddrT rsD, rtD, rsE, rtE, rdE, rdM, rdW;
	wordT aE, bE, immE, aluM, resultW;
	aluOpT aluOpE;
	logic aluSrcE, regWriteE, memReadE, memWriteE;
	logic regWriteM, memReadM, regWriteW;
	fwdSelT fwdAE, fwdBE;

	// any outstanding memory wait holds every stage
	assign freeze = instWait | dataWait;
	// branch flag for operand stalls, straight from the opcode in decode
	assign branchD = (instD[6:0] == opBranch);

	fetchStage uFetch (
		.clk(clk), .arstN(arstN), .freeze(freeze), .stallD(stallD), .flushD(flushD),
		.redirect(redirect), .target(target), .instData(instData),
		.instAddr(instAddr), .instD(instD), .pcD(pcD), .pcPlus4D(pcPlus4D)
	);

	decodeStage uDecode (
		.clk(clk), .arstN(arstN), .freeze(freeze), .stallD(stallD),
		.fwdAD(fwdAD), .fwdBD(fwdBD), .instD(instD), .pcD(pcD), .pcPlus4D(pcPlus4D),
		.aluM(aluM), .regWriteW(regWriteW), .rdW(rdW), .resultW(resultW),
		.redirect(redirect), .target(target), .rsD(rsD), .rtD(rtD),
		.aE(aE), .bE(bE), .immE(immE), .aluOpE(aluOpE), .aluSrcE(aluSrcE),
		.regWriteE(regWriteE), .memReadE(memReadE), .memWriteE(memWriteE),
		.rsE(rsE), .rtE(rtE), .rdE(rdE)
	);

	executeStage uExecute (
		.clk(clk), .arstN(arstN), .freeze(freeze), .dataWait(dataWait),
		.aE(aE), .bE(bE), .immE(immE), .aluOpE(aluOpE), .aluSrcE(aluSrcE),
		.regWriteE(regWriteE), .memReadE(memReadE), .memWriteE(memWriteE), .rdE(rdE),
		.fwdAE(fwdAE), .fwdBE(fwdBE), .dataRdata(dataRdata),
		.aluM(aluM), .regWriteM(regWriteM), .memReadM(memReadM), .rdM(rdM),
		.dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe), .dataReq(dataReq),
		.regWriteW(regWriteW), .rdW(rdW), .resultW(resultW)
	);

	hazardUnit uHazard (
		.rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE), .rdE(rdE), .rdM(rdM), .rdW(rdW),
		.regWriteE(regWriteE), .memReadE(memReadE), .regWriteM(regWriteM),
		.memReadM(memReadM), .regWriteW(regWriteW), .branchD(branchD), .redirect(redirect),
		.fwdAE(fwdAE), .fwdBE(fwdBE), .fwdAD(fwdAD), .fwdBD(fwdBD),
		.stallD(stallD), .flushD(flushD)
	);
endmodule

`default_nettype wire

//--- source/rvPkg.sv
/* rv32i subset definitions shared by the core
   widths, opcodes, alu operations and pipeline constants */
`default_nettype none

package rvPkg;
	localparam int xlen = 32;

	// pc, instruction and data word
	typedef logic [xlen-1:0] wordT;
	typedef logic [4:0] regAddrT;
	// operand source for execute
	typedef logic [1:0] fwdSelT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluPassB
	} aluOpT;

	localparam fwdSelT fwdReg = 2'd0;
	localparam fwdSelT fwdWb  = 2'd1;
	localparam fwdSelT fwdMem = 2'd2;

	// major opcodes
	localparam logic [6:0] opR      = 7'b0110011;
	localparam logic [6:0] opI      = 7'b0010011;
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;

	// branch funct3
	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;
	// r-type funct3, sub shares add with funct7 bit 5 set
	localparam logic [2:0] f3Add = 3'b000;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Xor = 3'b100;
	localparam logic [2:0] f3Or  = 3'b110;
	localparam logic [2:0] f3And = 3'b111;

	localparam wordT resetPc = '0;
	// addi x0, x0, 0
	localparam wordT nopInst = 32'h0000_0013;
endpackage

`default_nettype wire

//--- include/tbProgram.svh
/* core test program, one word per address from 0
   plus the stores it must produce, in order */
`ifndef TBPROGRAM_SVH
`define TBPROGRAM_SVH

localparam int progLen = 30;
localparam logic [31:0] progWords [progLen] = '{
	// addi x1 12, addi x2 10, add x3, sw x3
	32'h00C0_0093, 32'h00A0_0113, 32'h0020_81B3, 32'h0030_2023,
	// sub x4, sw, and x5, sw, or x6, sw
	32'h4021_8233, 32'h0040_2223, 32'h0022_72B3, 32'h0050_2423, 32'h0012_E333, 32'h0060_2623,
	// xor x7, sw, slt x8, sw, lui x9, sw
	32'h0023_43B3, 32'h0070_2823, 32'h0023_A433, 32'h0080_2A23, 32'h1234_54B7, 32'h0090_2C23,
	// lw x10 then dependent add x11 and its store
	32'h0040_2503, 32'h0015_05B3, 32'h00B0_2E23,
	// beq x11 x11 taken over two poison stores
	32'h00B5_8663, 32'h0200_2E23, 32'h0200_2E23,
	// bne not taken, its target is the last poison word
	32'h0031_9E63,
	// jal x13 over poison, store link, then spin on jal x0 0
	32'h00C0_06EF, 32'h0200_2E23, 32'h0200_2E23, 32'h02D0_2023, 32'h0000_006F,
	32'h0200_2E23, 32'h0200_2E23
};

// every poison word is sw x0, 60(x0)
localparam logic [31:0] poisonAddr = 32'd60;
localparam int numStores = 9;
localparam logic [31:0] expAddr [numStores] = '{0, 4, 8, 12, 16, 20, 24, 28, 32};
// last one is the jal link, pc 0x5c plus 4
localparam logic [31:0] expData [numStores] = '{
	22, 12, 8, 12, 6, 1, 32'h1234_5000, 24, 32'h0000_0060
};

`endif

//--- testbench/tbRiscvCore.sv
/* testbench for the five-stage core
   memory models with random wait, store checks, watchdog and report */
`timescale 1ns/1ps
`default_nettype none

module tbRiscvCore
	import rvPkg::*;
();
	`include "tbProgram.svh"

	localparam int dataWords = 64;
	// percent chance of a wait on each access
	localparam int waitPct = 30;
	// longest run of wait cycles on one access
	localparam int maxWait = 3;
	localparam int watchdogCycles = 40 * progLen * (maxWait + 1);
	// quiet cycles after the last store so late poison or duplicates still show
	localparam int drainCycles = 40;

	logic clk;
	logic arstN;
	wordT instAddr;
	wordT instData;
	logic instWait;
	wordT dataAddr;
	wordT dataWdata;
	wordT dataRdata;
	logic dataWe;
	logic dataReq;
	logic dataWait;

	wordT dataMem [dataWords];
	int storeCount;
	int checks;
	int testErr [1:5];
	int instRun;
	int dataRun;
	// data port as seen one cycle earlier
	logic prevWait, prevReq, prevWe;
	wordT prevAddr, prevWdata;

	riscvCore u_dut (
		.clk(clk), .arstN(arstN), .instAddr(instAddr), .instData(instData),
		.instWait(instWait), .dataAddr(dataAddr), .dataWdata(dataWdata),
		.dataWe(dataWe), .dataReq(dataReq), .dataRdata(dataRdata), .dataWait(dataWait)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// words past the program read as bubbles
	function automatic wordT fetchWord(wordT addr);
		int idx;
		idx = int'(addr >> 2);
		if (idx >= 0 && idx < progLen) begin
			return progWords[idx];
		end
		return nopInst;
	endfunction

	assign instData = fetchWord(instAddr);
	assign dataRdata = dataMem[dataAddr[7:2]];

	// store lands on the edge where the access is not held
	always @(posedge clk) begin
		if (dataReq && dataWe && !dataWait) begin
			dataMem[dataAddr[7:2]] <= dataWdata;
		end
	end

	// random wait per access with a capped run length
	always @(posedge clk) begin
		logic running;
		running = arstN;
		#1;
		if (!running) begin
			instWait = 1'b0;
			dataWait = 1'b0;
			instRun = 0;
			dataRun = 0;
		end else begin
			instWait = (instRun < maxWait) && (($urandom % 100) < waitPct);
			instRun = instWait ? instRun + 1 : 0;
			// data side only waits on a live request
			dataWait = dataReq && (dataRun < maxWait) && (($urandom % 100) < waitPct);
			dataRun = dataWait ? dataRun + 1 : 0;
		end
	end

	task automatic checkWord(string name, wordT expected, wordT actual, int test);
		checks++;
		assert (actual == expected) else begin
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			testErr[test]++;
		end
	endtask

	// which test a store index belongs to
	function automatic int storeTest(int idx);
		int test;
		test = 4;
		if (idx < 7) begin
			test = 2;
		end else if (idx == 7) begin
			test = 3;
		end
		return test;
	endfunction

	task automatic checkResetState();
		checks++;
		assert (!dataReq && !dataWe) else begin
			$display("at %0t ns the data port requests an access during reset", $time);
			testErr[1]++;
		end
		checkWord("instAddr", resetPc, instAddr, 1);
	endtask

	task automatic checkStore();
		logic poison;
		poison = (dataAddr == poisonAddr);
		checks++;
		// flushed or skipped slots all store to the poison address
		assert (!poison) else begin
			$display("at %0t ns a store from a flushed or skipped slot reached the data port",
				$time);
			testErr[4]++;
		end
		if (!poison) begin
			checks++;
			assert (storeCount < numStores) else begin
				$display("at %0t ns an extra store to %h came after the expected list",
					$time, dataAddr);
				testErr[5]++;
			end
		end
		if (!poison && storeCount < numStores) begin
			checkWord("dataAddr", expAddr[storeCount], dataAddr, storeTest(storeCount));
			checkWord("dataWdata", expData[storeCount], dataWdata, storeTest(storeCount));
			storeCount++;
		end
	endtask

	task automatic reportTest(int num, string name);
		if (testErr[num] == 0) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: FAIL, %0d errors", num, name, testErr[num]);
		end
	endtask

	// sampled between edges where the port is settled
	always @(negedge clk) begin
		if (!arstN) begin
			checkResetState();
		end else begin
			if (dataReq && dataWe && !dataWait) begin
				checkStore();
			end
			// a held access keeps its request, address, data and direction
			if (prevWait && prevReq) begin
				checkWord("dataReq", 32'd1, {31'b0, dataReq}, 5);
				checkWord("dataAddr", prevAddr, dataAddr, 5);
				checkWord("dataWdata", prevWdata, dataWdata, 5);
				checkWord("dataWe", {31'b0, prevWe}, {31'b0, dataWe}, 5);
			end
		end
		prevWait = dataWait;
		prevReq = dataReq;
		prevWe = dataWe;
		prevAddr = dataAddr;
		prevWdata = dataWdata;
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout after %0d cycles with %0d of %0d stores seen",
			watchdogCycles, storeCount, numStores);
		$display("Test failed");
		$finish;
	end

	initial begin
		int failedTests;
		int errors;
		void'($urandom(96));
		arstN = 1'b0;
		instWait = 1'b0;
		dataWait = 1'b0;
		storeCount = 0;
		checks = 0;
		instRun = 0;
		dataRun = 0;
		prevWait = 1'b0;
		prevReq = 1'b0;
		prevWe = 1'b0;
		prevAddr = '0;
		prevWdata = '0;
		for (int t = 1; t <= 5; t++) begin
			testErr[t] = 0;
		end
		// fill tagged with the word index
		for (int i = 0; i < dataWords; i++) begin
			dataMem[i] <= 32'hDA7A_0000 | wordT'(i);
		end

		repeat (5) @(posedge clk);
		#1;
		arstN = 1'b1;
		// still at reset pc before the first edge out of reset
		@(negedge clk);
		checkResetState();
		reportTest(1, "reset state");

		wait (storeCount >= 7);
		reportTest(2, "arithmetic and forwarding");
		wait (storeCount >= 8);
		reportTest(3, "load-use");
		wait (storeCount >= numStores);
		repeat (drainCycles) @(posedge clk);
		reportTest(4, "branches and jumps");
		reportTest(5, "wait back-pressure");

		failedTests = 0;
		errors = 0;
		for (int t = 1; t <= 5; t++) begin
			if (testErr[t] != 0) begin
				failedTests++;
			end
			errors += testErr[t];
		end
		$display("tests 5, failed %0d, checks %0d, errors %0d", failedTests, checks, errors);
		if (failedTests == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end
endmodule

`default_nettype wire
